/* hdl/mulPkg.sv */
// Multiply unit package
// Holds the widths, counts, data types and the request and response
// structs that are shared by every stage of the pipelined multiplier.
// The unit returns the low half of a 32 by 32 bit unsigned product.

package mulPkg;

    // Width of the operands and of the returned product
    localparam int dataWidth = 32;

    // Each operand is cut into slices of this width before multiplying
    localparam int nibbleWidth = 4;

    // Number of slices per operand
    localparam int nibbleCount = dataWidth / nibbleWidth;

    // One partial product for every pair of multiplicand and multiplier slices
    localparam int productCount = nibbleCount * nibbleCount;

    // Width of the tag that the issuing stage attaches to a request
    localparam int tagWidth = 4;

    // A full data word
    // Used for operands, for every partial product and for the final product
    typedef logic [dataWidth-1:0] word_t;

    // Identifies a request so that the issuer can match its result
    typedef logic [tagWidth-1:0] tag_t;

    // Request presented to the unit together with reqValid
    typedef struct packed {
        // Left operand of the multiplication
        word_t multiplicand;
        // Right operand of the multiplication
        word_t multiplier;
        // Returned unchanged with the matching response
        tag_t tag;
    } mulReq_t;

    // Response driven by the unit together with respValid
    typedef struct packed {
        // Low dataWidth bits of multiplicand times multiplier
        word_t product;
        // Copy of the tag of the request that produced this result
        tag_t tag;
    } mulResp_t;

endpackage

/* hdl/nibbleProductArray.sv */
// Nibble product array
// First arithmetic stage of the multiplier. Every nibble of the
// multiplicand is multiplied by every nibble of the multiplier, each
// product is shifted to its weight and the whole bank is registered.

module nibbleProductArray (
    input  logic          clock,
    input  logic          advance,
    input  mulPkg::word_t multiplicand,
    input  mulPkg::word_t multiplier,
    output mulPkg::word_t partialProducts [mulPkg::productCount]
);

    // Combinational bank that is captured on the next advancing edge
    mulPkg::word_t productNext [mulPkg::productCount];

    // Multiplies two slices and places the result at its bit weight
    // The weight is counted in nibbles, so slice pair (i, j) has weight i + j
    function automatic mulPkg::word_t shiftedProduct(
        input logic [mulPkg::nibbleWidth-1:0] a,
        input logic [mulPkg::nibbleWidth-1:0] b,
        input int                             weight
    );
        mulPkg::word_t widened;
        // Widen before multiplying so the 8-bit product is not cut short
        widened = mulPkg::word_t'(a) * mulPkg::word_t'(b);
        // Bits shifted past dataWidth are lost, which matches a low-half result
        return widened << (mulPkg::nibbleWidth * weight);
    endfunction

    // Build all slice pairs
    // Entry i * nibbleCount + j holds multiplicand nibble i times multiplier nibble j
    always_comb begin
        for (int i = 0; i < mulPkg::nibbleCount; i++) begin
            for (int j = 0; j < mulPkg::nibbleCount; j++) begin
                productNext[i*mulPkg::nibbleCount+j] = shiftedProduct(
                    multiplicand[i*mulPkg::nibbleWidth +: mulPkg::nibbleWidth],
                    multiplier[j*mulPkg::nibbleWidth +: mulPkg::nibbleWidth],
                    i + j
                );
            end
        end
    end

    // Pairs whose weight reaches dataWidth contribute nothing
    // They still occupy a slot so that the adder tree stays regular

    // Stage register
    // While the pipeline is stalled the bank keeps its previous contents
    always_ff @(posedge clock) begin
        if (advance) begin
            partialProducts <= productNext;
        end
    end

endmodule

/* hdl/partialSumStage.sv */
// Partial sum stage
// Halving adder stage of the multiplier. Neighbouring entries of the
// incoming bank are added in pairs and the half-size bank is registered.
// It is used twice, reducing 64 entries to 32 and then 32 to 16.

module partialSumStage #(
    parameter int inputCount = 64
) (
    input  logic          clock,
    input  logic          advance,
    input  mulPkg::word_t sumsIn  [inputCount],
    output mulPkg::word_t sumsOut [inputCount/2]
);

    // Output k takes inputs 2k and 2k + 1
    // The adders wrap at dataWidth bits, so only the low product half survives
    always_ff @(posedge clock) begin
        if (advance) begin
            for (int k = 0; k < inputCount / 2; k++) begin
                sumsOut[k] <= sumsIn[2*k] + sumsIn[2*k+1];
            end
        end
    end

    // Pairing leaves one entry without a partner when the count is odd
    // That entry would silently drop out of the product
    evenInputCount : assert property (
        @(posedge clock) (inputCount % 2) == 0
    ) else $error("partialSumStage needs an even inputCount, got %0d", inputCount);

endmodule

/* hdl/partialProductSum.sv */
// Final partial product sum
// Last stage of the multiplier. The sixteen partial sums left after the
// halving stages are folded by an adder tree into a single word, which
// is registered as the product of the operation in this stage.

module partialProductSum (
    input  logic          clock,
    input  logic          advance,
    input  mulPkg::word_t sumsIn [mulPkg::productCount/4],
    output mulPkg::word_t product
);

    // Levels of the adder tree, each half the size of the one above it
    mulPkg::word_t levelEight [8];
    mulPkg::word_t levelFour  [4];
    mulPkg::word_t levelTwo   [2];

    // Root of the tree, captured into product
    mulPkg::word_t treeSum;

    // Pairwise folding keeps the tree depth at four adders
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            levelEight[k] = sumsIn[2*k] + sumsIn[2*k+1];
        end
        for (int k = 0; k < 4; k++) begin
            levelFour[k] = levelEight[2*k] + levelEight[2*k+1];
        end
        for (int k = 0; k < 2; k++) begin
            levelTwo[k] = levelFour[2*k] + levelFour[2*k+1];
        end
        // Carries beyond dataWidth belong to the high half and are dropped
        treeSum = levelTwo[0] + levelTwo[1];
    end

    // Output register of the pipeline
    // It holds while a response is waiting for respReady
    always_ff @(posedge clock) begin
        if (advance) begin
            product <= treeSum;
        end
    end

endmodule

/* hdl/mulPipeline.sv */
// Pipelined multiply unit
// Accepts one MUL request per cycle and returns the low 32 bits of the
// product five stages later, in acceptance order, with its tag attached.
// A single advance signal moves or freezes the whole pipeline, so a
// stalled response holds and nothing inside is dropped or duplicated.

module mulPipeline (
    input  logic             clock,
    input  logic             rstN,
    input  logic             reqValid,
    output logic             reqReady,
    input  mulPkg::mulReq_t  req,
    output logic             respValid,
    input  logic             respReady,
    output mulPkg::mulResp_t resp
);

    // High when every stage register may take its next value
    logic advance;

    // Valid bit of each stage from the operand register at index 0 to the output at index 4
    logic [4:0] stageValid;

    // Tag of the operation held in each stage
    mulPkg::tag_t stageTag [0:4];

    // S0 operand register
    mulPkg::word_t operandA;
    mulPkg::word_t operandB;

    // Data passed between the arithmetic stages
    mulPkg::word_t s1Products [mulPkg::productCount];
    mulPkg::word_t s2Sums     [mulPkg::productCount/2];
    mulPkg::word_t s3Sums     [mulPkg::productCount/4];
    mulPkg::word_t s4Product;

    // The only reason to stop is a result that the consumer has not taken
    // An empty output slot or a consumed result lets everything move
    assign advance  = !(respValid && !respReady);
    assign reqReady = advance;

    // The valid bit of the output stage is the response valid
    assign respValid = stageValid[4];

    assign resp = '{product: s4Product, tag: stageTag[4]};

    // Valid chain
    // A request enters exactly when reqValid is high and the pipeline advances
    always_ff @(posedge clock) begin
        if (!rstN) begin
            stageValid <= '0;
        end else if (advance) begin
            stageValid <= {stageValid[3:0], reqValid};
        end
    end

    // Operand register and the tag of every stage
    always_ff @(posedge clock) begin
        if (advance) begin
            operandA    <= req.multiplicand;
            operandB    <= req.multiplier;
            stageTag[0] <= req.tag;
            for (int s = 1; s < 5; s++) begin
                stageTag[s] <= stageTag[s-1];
            end
        end
    end

    // S1 registers the shifted nibble products
    nibbleProductArray productArray (
        .clock           (clock),
        .advance         (advance),
        .multiplicand    (operandA),
        .multiplier      (operandB),
        .partialProducts (s1Products)
    );

    // S2 reduces 64 partial products to 32
    partialSumStage #(
        .inputCount (mulPkg::productCount)
    ) reduceStage1 (
        .clock   (clock),
        .advance (advance),
        .sumsIn  (s1Products),
        .sumsOut (s2Sums)
    );

    // S3 reduces 32 to 16
    partialSumStage #(
        .inputCount (mulPkg::productCount/2)
    ) reduceStage2 (
        .clock   (clock),
        .advance (advance),
        .sumsIn  (s2Sums),
        .sumsOut (s3Sums)
    );

    // S4 folds the rest into the product
    partialProductSum finalSum (
        .clock   (clock),
        .advance (advance),
        .sumsIn  (s3Sums),
        .product (s4Product)
    );

    // The request side may only be open when the output is not blocked
    readyFollowsOutput : assert property (
        @(posedge clock) disable iff (!rstN)
        reqReady == !(respValid && !respReady)
    ) else $error("reqReady does not follow the output handshake");

    // A refused response must be presented again unchanged on the next cycle
    stalledRespStable : assert property (
        @(posedge clock) disable iff (!rstN)
        respValid && !respReady |=> respValid && $stable(resp)
    ) else $error("resp changed while stalled");

    // Every valid bit is known once reset has been applied
    validKnown : assert property (
        @(posedge clock) disable iff (!rstN)
        !$isunknown(stageValid)
    ) else $error("unknown valid bit in the pipeline");

endmodule

/* sim/mulTb.sv */
// Testbench for the pipelined multiply unit
// Directed tests drive mulPipeline through reset, corner operands,
// latency, back-to-back streams, back-pressure and idle gaps.
// A negedge monitor keeps a queue of expected responses and compares
// every response, in order, against the reference product.

module mulTb;

    // Longest wait in cycles before a wait loop gives up
    localparam int waitLimit = 200;

    logic             clock;
    logic             rstN;
    logic             reqValid;
    logic             reqReady;
    mulPkg::mulReq_t  req;
    logic             respValid;
    logic             respReady;
    mulPkg::mulResp_t resp;

    // Seed of the random stream, advanced by every $random call
    integer seed = 32'h91ab;

    // Expected responses in acceptance order
    mulPkg::mulResp_t expectQueue [$];
    mulPkg::mulResp_t expected;
    int acceptedCount = 0;
    int respondedCount = 0;

    // Stall tracking for the hold check
    logic             wasStalled;
    mulPkg::mulResp_t heldResp;

    mulPipeline dut0 (
        .clock     (clock),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .req       (req),
        .respValid (respValid),
        .respReady (respReady),
        .resp      (resp)
    );

    always #2 clock = ~clock;

    // Prints the reason and the fail message, then ends the run
    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkWord(
        input string         name,
        input mulPkg::word_t want,
        input mulPkg::word_t got
    );
        if (got !== want) begin
            stopWithFailure($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                                      $time, name, want, got));
        end
    endtask

    task automatic checkTag(
        input string        name,
        input mulPkg::tag_t want,
        input mulPkg::tag_t got
    );
        if (got !== want) begin
            stopWithFailure($sformatf("CHECK FAILED at %0t: %s expected %h, got %h",
                                      $time, name, want, got));
        end
    endtask

    task automatic checkBit(input string name, input logic want, input logic got);
        if (got !== want) begin
            stopWithFailure($sformatf("CHECK FAILED at %0t: %s expected %b, got %b",
                                      $time, name, want, got));
        end
    endtask

    // Reference model giving the low half of the exact 64-bit product
    function automatic mulPkg::word_t referenceProduct(
        input mulPkg::word_t a,
        input mulPkg::word_t b
    );
        logic [63:0] full;
        full = {32'd0, a} * {32'd0, b};
        return full[31:0];
    endfunction

    function automatic mulPkg::mulReq_t randomRequest(input mulPkg::tag_t tag);
        mulPkg::mulReq_t r;
        r.multiplicand = $random(seed);
        r.multiplier   = $random(seed);
        r.tag          = tag;
        return r;
    endfunction

    function automatic logic randomBit();
        logic [31:0] r;
        r = $random(seed);
        return r[0];
    endfunction

    // Monitor
    // Inputs change only at posedge, so the negedge sees the levels that the next
    // edge will act on. Responses are popped before requests are pushed, since a
    // request accepted on this edge cannot come out on the same edge
    always @(negedge clock) begin
        if (!rstN) begin
            wasStalled = 1'b0;
        end else begin
            checkBit("reqReady", !(respValid && !respReady), reqReady);
            // A refused response has to be presented again unchanged
            if (wasStalled) begin
                checkBit("respValid", 1'b1, respValid);
                checkWord("resp.product", heldResp.product, resp.product);
                checkTag("resp.tag", heldResp.tag, resp.tag);
            end
            if (respValid && respReady) begin
                if (expectQueue.size() == 0) begin
                    stopWithFailure("A response arrived with no request outstanding");
                end
                expected = expectQueue.pop_front();
                checkWord("resp.product", expected.product, resp.product);
                checkTag("resp.tag", expected.tag, resp.tag);
                respondedCount++;
            end
            if (reqValid && reqReady) begin
                expectQueue.push_back('{
                    product: referenceProduct(req.multiplicand, req.multiplier),
                    tag:     req.tag
                });
                acceptedCount++;
            end
            wasStalled = respValid && !respReady;
            heldResp   = resp;
        end
    end

    // Presents one request and returns on the edge that accepts it
    task automatic issueOne(input mulPkg::word_t a, input mulPkg::word_t b, input mulPkg::tag_t t);
        int waited;
        waited = 0;
        @(posedge clock);
        reqValid <= 1'b1;
        req      <= '{multiplicand: a, multiplier: b, tag: t};
        @(negedge clock);
        while (!reqReady && waited <= waitLimit) begin
            @(negedge clock);
            waited++;
        end
        if (!reqReady) begin
            stopWithFailure("TIMEOUT: the request was never accepted");
        end
        @(posedge clock);
        reqValid <= 1'b0;
    endtask

    // Returns at the negedge where respValid is high
    task automatic waitResponse();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!respValid && waited <= waitLimit) begin
            @(negedge clock);
            waited++;
        end
        if (!respValid) begin
            stopWithFailure("TIMEOUT: no response arrived in time");
        end
    endtask

    // Waits until every accepted request has been answered, then checks the output is empty
    task automatic waitDrain();
        int waited;
        waited = 0;
        @(posedge clock);
        while (respondedCount != acceptedCount && waited <= waitLimit) begin
            @(posedge clock);
            waited++;
        end
        if (respondedCount != acceptedCount) begin
            stopWithFailure("TIMEOUT: no response arrived in time for every accepted request");
        end
        @(negedge clock);
        checkBit("respValid", 1'b0, respValid);
        if (expectQueue.size() != 0) begin
            stopWithFailure("Expected responses are left over after the pipeline drained");
        end
    endtask

    task automatic verifyResetLevels();
        @(negedge clock);
        checkBit("respValid", 1'b0, respValid);
        checkBit("reqReady", 1'b1, reqReady);
    endtask

    // One operation at a time, compared with a known product
    task automatic runSingle(
        input mulPkg::word_t a,
        input mulPkg::word_t b,
        input mulPkg::word_t want,
        input mulPkg::tag_t  t
    );
        issueOne(a, b, t);
        waitResponse();
        checkWord("resp.product", want, resp.product);
        checkTag("resp.tag", t, resp.tag);
        waitDrain();
    endtask

    task automatic multiplyCorners();
        runSingle(32'h0000_0000, 32'h1234_5678, 32'h0000_0000, 4'h1);
        runSingle(32'h0000_0001, 32'h1234_5678, 32'h1234_5678, 4'h2);
        // All ones squared is 2^64 - 2^33 + 1, whose low half is one
        runSingle(32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 4'h3);
        runSingle(32'h8000_0000, 32'h0000_0002, 32'h0000_0000, 4'h4);
        // Nines against all ones, so carries ripple through each column
        runSingle(32'h9999_9999, 32'hffff_ffff,
                  referenceProduct(32'h9999_9999, 32'hffff_ffff), 4'h5);
        runSingle(32'hfedc_ba98, 32'h7654_3210,
                  referenceProduct(32'hfedc_ba98, 32'h7654_3210), 4'h6);
        runSingle(32'h0000_ffff, 32'h0001_0001, 32'hffff_ffff, 4'h7);
    endtask

    // The request is accepted on edge A, so respValid stays low after A to A+3
    // and rises after A+4, the fifth edge after the edge that drove the request
    task automatic measureLatency();
        issueOne(32'h0000_0007, 32'h0000_0006, 4'h9);
        for (int k = 0; k < 5; k++) begin
            @(negedge clock);
            checkBit("respValid", k == 4, respValid);
        end
        checkWord("resp.product", 32'h0000_002a, resp.product);
        waitDrain();
    endtask

    task automatic streamBackToBack();
        for (int i = 0; i < 40; i++) begin
            @(posedge clock);
            reqValid <= 1'b1;
            req      <= randomRequest(i[3:0]);
            @(negedge clock);
            checkBit("reqReady", 1'b1, reqReady);
        end
        @(posedge clock);
        reqValid <= 1'b0;
        waitDrain();
    endtask

    // A continuous stream with respReady dropped from cycle 12 to cycle 19
    task automatic holdUnderBackPressure();
        int   issued;
        int   cycle;
        logic accepted;
        issued = 0;
        cycle  = 0;
        @(posedge clock);
        reqValid <= 1'b1;
        req      <= randomRequest(4'h0);
        while (issued < 30 && cycle <= waitLimit) begin
            @(negedge clock);
            accepted = reqValid && reqReady;
            // The pipeline is full by now, so the stall must reach the request side
            if (!respReady) begin
                checkBit("respValid", 1'b1, respValid);
                checkBit("reqReady", 1'b0, reqReady);
            end
            @(posedge clock);
            if (accepted) begin
                issued++;
                req <= randomRequest(issued[3:0]);
            end
            reqValid  <= issued < 30;
            respReady <= !(cycle >= 11 && cycle < 19);
            cycle++;
        end
        if (issued < 30) begin
            stopWithFailure("TIMEOUT: the back-pressure stream was not accepted in time");
        end
        respReady <= 1'b1;
        waitDrain();
    endtask

    // Random gaps on both sides; a presented request holds until it is taken
    task automatic streamWithGaps();
        int   startAccepted;
        logic accepted;
        startAccepted = acceptedCount;
        accepted      = 1'b0;
        @(posedge clock);
        for (int cycle = 0; cycle < 120; cycle++) begin
            if (!reqValid || accepted) begin
                reqValid <= randomBit();
                req      <= randomRequest(cycle[3:0]);
            end
            respReady <= randomBit();
            @(negedge clock);
            accepted = reqValid && reqReady;
            @(posedge clock);
        end
        reqValid  <= 1'b0;
        respReady <= 1'b1;
        waitDrain();
        if (acceptedCount == startAccepted) begin
            stopWithFailure("The idle gap test accepted no request at all");
        end
    endtask

    initial begin
        clock     = 1'b0;
        rstN      = 1'b0;
        reqValid  = 1'b0;
        req       = '0;
        respReady = 1'b1;
        repeat (2) @(posedge clock);
        rstN <= 1'b1;

        verifyResetLevels();
        multiplyCorners();
        measureLatency();
        streamBackToBack();
        holdUnderBackPressure();
        streamWithGaps();

        $display("** PASS **");
        $finish;
    end

endmodule

/* vlog.f */
hdl/mulPkg.sv
hdl/nibbleProductArray.sv
hdl/partialSumStage.sv
hdl/partialProductSum.sv
hdl/mulPipeline.sv
sim/mulTb.sv

/* Bender.yml */
package:
  name: mul_pipeline

sources:
  - files:
      - hdl/mulPkg.sv
      - hdl/nibbleProductArray.sv
      - hdl/partialSumStage.sv
      - hdl/partialProductSum.sv
      - hdl/mulPipeline.sv
  - target: simulation
    files:
      - sim/mulTb.sv
